// File: Bender.yml
package:
  name: uart_gpio

sources:
  - rtl/u2g_pkg.sv
  - rtl/credit_link_if.sv
  - rtl/uart_rx.sv
  - rtl/uart_tx.sv
  - rtl/cmd_parser.sv
  - rtl/credit_fifo.sv
  - rtl/gpio_exec.sv
  - rtl/resp_sender.sv
  - rtl/uart_gpio_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_uart_gpio.sv

// File: rtl/cmd_parser.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_parser #(
   parameter int CREDITS = 4
) (
   input  logic       clk,
   input  logic       nRst,
   input  logic [7:0] data,
   input  logic       byte_valid,
   credit_link_if.tx  cmd
);

   localparam int CNT_W = $clog2(CREDITS + 1);

   typedef enum logic [2:0] {ST_IDLE, ST_BANK, ST_PIN, ST_ARG, ST_ISSUE} state_t;

   state_t             state;
   u2g_pkg::cmd_kind_t kind;
   logic [7:0]         bank;
   logic [7:0]         pin;
   logic               arg;
   logic [CNT_W-1:0]   credit_cnt;
   logic               frame_done;
   logic               issue;

   assign frame_done = byte_valid &&
                       ((state == ST_ARG) || (state == ST_PIN && kind == u2g_pkg::CMD_READ));
   assign issue      = (credit_cnt != '0) && (frame_done || state == ST_ISSUE);
   assign cmd.payload = '{kind: kind, bank: bank, pin: pin, arg: arg};

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state      <= ST_IDLE;
         kind       <= u2g_pkg::CMD_READ;
         bank       <= '0;
         pin        <= '0;
         arg        <= 1'b0;
         cmd.valid  <= 1'b0;
         credit_cnt <= CNT_W'(CREDITS);
      end else begin
         cmd.valid <= issue;
         case ({issue, cmd.credit})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
         case (state)
            ST_IDLE: begin
               if (byte_valid) begin
                  state <= ST_BANK;
                  case (data)
                     u2g_pkg::OP_READ:   kind <= u2g_pkg::CMD_READ;
                     u2g_pkg::OP_WRITE:  kind <= u2g_pkg::CMD_WRITE;
                     u2g_pkg::OP_CONFIG: kind <= u2g_pkg::CMD_CONFIG;
                     default:            state <= ST_IDLE;   // Not an opcode.
                  endcase
               end
            end
            ST_BANK: begin
               if (byte_valid) begin
                  bank  <= data;
                  state <= ST_PIN;
               end
            end
            ST_PIN: begin
               if (byte_valid) begin
                  pin <= data;
                  arg <= 1'b0;
                  if (kind != u2g_pkg::CMD_READ) state <= ST_ARG;
                  else state <= issue ? ST_IDLE : ST_ISSUE;
               end
            end
            ST_ARG: begin
               if (byte_valid) begin
                  arg   <= data[0];
                  state <= issue ? ST_IDLE : ST_ISSUE;
               end
            end
            ST_ISSUE: begin
               if (issue) state <= ST_IDLE;   // Bytes seen while waiting are dropped.
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   a_valid_has_credit: assert property (@(posedge clk) disable iff (!nRst)
      cmd.valid |-> $past(credit_cnt) != '0);

endmodule

`default_nettype wire

// File: rtl/credit_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module credit_fifo #(
   parameter type payload_t   = logic,
   parameter int  DEPTH       = 4,
   parameter int  OUT_CREDITS = 1
) (
   input  logic      clk,
   input  logic      nRst,
   credit_link_if.rx in,
   credit_link_if.tx out
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam int CRD_W = $clog2(OUT_CREDITS + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CRD_W-1:0] out_cnt;
   logic             send;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // An item arriving at an empty queue goes straight out in the same cycle.
   assign send = ((count != '0) || in.valid) && (out_cnt != '0);

   always_ff @(posedge clk) begin
      if (in.valid) mem[wr_ptr] <= in.payload;
      if (send) out.payload <= (count == '0) ? in.payload : mem[rd_ptr];
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         out_cnt   <= CRD_W'(OUT_CREDITS);
         out.valid <= 1'b0;
         in.credit <= 1'b0;
      end else begin
         out.valid <= send;
         in.credit <= send;   // Each departure frees one slot upstream.
         if (in.valid) wr_ptr <= next_ptr(wr_ptr);
         if (send) rd_ptr <= next_ptr(rd_ptr);
         case ({in.valid, send})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         case ({send, out.credit})
            2'b10:   out_cnt <= out_cnt - 1'b1;
            2'b01:   out_cnt <= out_cnt + 1'b1;
            default: out_cnt <= out_cnt;
         endcase
      end
   end

   a_no_write_when_full: assert property (@(posedge clk) disable iff (!nRst)
      in.valid |-> count < CNT_W'(DEPTH));

   a_send_with_credit: assert property (@(posedge clk) disable iff (!nRst)
      out.valid |-> $past(out_cnt) != '0);

endmodule

`default_nettype wire

// File: rtl/credit_link_if.sv
`timescale 1ns/1ns
`default_nettype none

interface credit_link_if #(
   parameter type payload_t = logic
) ();

   logic     valid;     // One cycle per item.
   payload_t payload;
   logic     credit;    // One cycle per entry freed at the receiver.

   modport tx (output valid, output payload, input credit);
   modport rx (input valid, input payload, output credit);

endinterface

`default_nettype wire

// File: rtl/gpio_exec.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_exec #(
   parameter int NUM_BANKS   = 4,
   parameter int RSP_CREDITS = 4
) (
   input  logic                                  clk,
   input  logic                                  nRst,
   credit_link_if.rx                             cmd,
   credit_link_if.tx                             rsp,
   input  logic [NUM_BANKS*u2g_pkg::BANK_W-1:0] gpio_in,
   output logic [NUM_BANKS*u2g_pkg::BANK_W-1:0] gpio_out,
   output logic [NUM_BANKS*u2g_pkg::BANK_W-1:0] gpio_oe
);

   localparam int GPIO_W = NUM_BANKS * u2g_pkg::BANK_W;
   localparam int IDX_W  = $clog2(GPIO_W);
   localparam int CRD_W  = $clog2(RSP_CREDITS + 1);

   u2g_pkg::cmd_t    held;
   u2g_pkg::cmd_t    cur;
   logic             pending;
   logic             go;
   logic             in_range;
   logic [IDX_W-1:0] idx;
   logic [CRD_W-1:0] credit_cnt;
   logic [GPIO_W-1:0] gpio_meta;
   logic [GPIO_W-1:0] gpio_sync;

   assign cur      = pending ? held : cmd.payload;
   assign go       = (pending || cmd.valid) && (credit_cnt != '0);
   assign in_range = (cur.bank < NUM_BANKS) && (cur.pin < u2g_pkg::BANK_W);
   assign idx      = IDX_W'(cur.bank * u2g_pkg::BANK_W + cur.pin);

   always_ff @(posedge clk) begin
      gpio_meta <= gpio_in;
      gpio_sync <= gpio_meta;
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         held        <= '0;
         pending     <= 1'b0;
         gpio_out    <= '0;
         gpio_oe     <= '0;
         credit_cnt  <= CRD_W'(RSP_CREDITS);
         rsp.valid   <= 1'b0;
         rsp.payload <= '0;
         cmd.credit  <= 1'b0;
      end else begin
         rsp.valid  <= go;
         cmd.credit <= go;
         if (cmd.valid && !go) begin
            held    <= cmd.payload;   // Parked until a response slot opens.
            pending <= 1'b1;
         end else if (go) begin
            pending <= 1'b0;
         end
         case ({go, rsp.credit})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
         if (go) begin
            rsp.payload.has_data <= 1'b0;
            rsp.payload.data     <= 1'b0;
            rsp.payload.code     <= u2g_pkg::RSP_ERROR;
            if (in_range) begin
               case (cur.kind)
                  u2g_pkg::CMD_READ: begin
                     rsp.payload.code     <= u2g_pkg::RSP_READ;
                     rsp.payload.has_data <= 1'b1;
                     rsp.payload.data     <= gpio_sync[idx];
                  end
                  u2g_pkg::CMD_WRITE: begin
                     rsp.payload.code <= u2g_pkg::RSP_WRITE;
                     gpio_out[idx]    <= cur.arg;
                  end
                  u2g_pkg::CMD_CONFIG: begin
                     rsp.payload.code <= u2g_pkg::RSP_CONFIG;
                     gpio_oe[idx]     <= cur.arg;
                  end
                  default: rsp.payload.code <= u2g_pkg::RSP_ERROR;
               endcase
            end
         end
      end
   end

   a_single_slot: assert property (@(posedge clk) disable iff (!nRst)
      cmd.valid |-> !pending);

endmodule

`default_nettype wire

// File: rtl/resp_sender.sv
`timescale 1ns/1ns
`default_nettype none

module resp_sender (
   input  logic       clk,
   input  logic       nRst,
   credit_link_if.rx  rsp,
   output logic [7:0] data,
   output logic       start,
   input  logic       busy
);

   typedef enum logic [1:0] {S_IDLE, S_LAUNCH, S_WAIT} state_t;

   state_t state;
   logic   data_pending;
   logic   data_bit;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state        <= S_IDLE;
         data         <= '0;
         start        <= 1'b0;
         data_pending <= 1'b0;
         data_bit     <= 1'b0;
         rsp.credit   <= 1'b0;
      end else begin
         start      <= 1'b0;
         rsp.credit <= 1'b0;
         case (state)
            S_IDLE: begin
               if (rsp.valid) begin
                  data         <= rsp.payload.code;
                  data_pending <= rsp.payload.has_data;
                  data_bit     <= rsp.payload.data;
                  start        <= 1'b1;
                  state        <= S_LAUNCH;
               end
            end
            S_LAUNCH: state <= S_WAIT;   // Busy from the transmitter shows up a cycle late.
            S_WAIT: begin
               if (!busy) begin
                  if (data_pending) begin
                     data         <= {7'b0011000, data_bit};   // ASCII '0' or '1'.
                     data_pending <= 1'b0;
                     start        <= 1'b1;
                     state        <= S_LAUNCH;
                  end else begin
                     rsp.credit <= 1'b1;
                     state      <= S_IDLE;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   a_valid_only_idle: assert property (@(posedge clk) disable iff (!nRst)
      rsp.valid |-> state == S_IDLE);

endmodule

`default_nettype wire

// File: rtl/u2g_pkg.sv
`default_nettype none

package u2g_pkg;

   localparam int BANK_W = 8;

   localparam logic [7:0] OP_READ   = 8'h30;
   localparam logic [7:0] OP_WRITE  = 8'h31;
   localparam logic [7:0] OP_CONFIG = 8'h32;

   localparam logic [7:0] RSP_READ   = 8'h33;
   localparam logic [7:0] RSP_WRITE  = 8'h34;
   localparam logic [7:0] RSP_CONFIG = 8'h35;
   localparam logic [7:0] RSP_ERROR  = 8'h3f;

   typedef enum logic [1:0] {
      CMD_READ,
      CMD_WRITE,
      CMD_CONFIG
   } cmd_kind_t;

   typedef struct packed {
      cmd_kind_t  kind;
      logic [7:0] bank;
      logic [7:0] pin;
      logic       arg;   // Output value or direction, bit 0 of the last byte.
   } cmd_t;

   typedef struct packed {
      logic [7:0] code;
      logic       has_data;   // A second byte '0' or '1' follows the code.
      logic       data;
   } rsp_t;

endpackage

`default_nettype wire

// File: rtl/uart_gpio_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_gpio_top #(
   parameter int CLKS_PER_BIT = 16,
   parameter int NUM_BANKS    = 4,
   parameter int CMD_DEPTH    = 4,
   parameter int RSP_DEPTH    = 4
) (
   input  logic                                  clk,
   input  logic                                  nRst,
   input  logic                                  rx,
   output logic                                  tx,
   input  logic [NUM_BANKS*u2g_pkg::BANK_W-1:0] gpio_in,
   output logic [NUM_BANKS*u2g_pkg::BANK_W-1:0] gpio_out,
   output logic [NUM_BANKS*u2g_pkg::BANK_W-1:0] gpio_oe
);

   logic [7:0] rx_data;
   logic       rx_valid;
   logic [7:0] tx_data;
   logic       tx_start;
   logic       tx_busy;

   credit_link_if #(.payload_t(u2g_pkg::cmd_t)) cmd_in ();
   credit_link_if #(.payload_t(u2g_pkg::cmd_t)) cmd_out ();
   credit_link_if #(.payload_t(u2g_pkg::rsp_t)) rsp_in ();
   credit_link_if #(.payload_t(u2g_pkg::rsp_t)) rsp_out ();

   uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
      .clk        (clk),
      .nRst       (nRst),
      .rx         (rx),
      .data       (rx_data),
      .byte_valid (rx_valid)
   );

   cmd_parser #(.CREDITS(CMD_DEPTH)) i_cmd_parser (
      .clk        (clk),
      .nRst       (nRst),
      .data       (rx_data),
      .byte_valid (rx_valid),
      .cmd        (cmd_in)
   );

   credit_fifo #(
      .payload_t   (u2g_pkg::cmd_t),
      .DEPTH       (CMD_DEPTH),
      .OUT_CREDITS (1)
   ) i_cmd_fifo (
      .clk  (clk),
      .nRst (nRst),
      .in   (cmd_in),
      .out  (cmd_out)
   );

   gpio_exec #(
      .NUM_BANKS   (NUM_BANKS),
      .RSP_CREDITS (RSP_DEPTH)
   ) i_gpio_exec (
      .clk      (clk),
      .nRst     (nRst),
      .cmd      (cmd_out),
      .rsp      (rsp_in),
      .gpio_in  (gpio_in),
      .gpio_out (gpio_out),
      .gpio_oe  (gpio_oe)
   );

   credit_fifo #(
      .payload_t   (u2g_pkg::rsp_t),
      .DEPTH       (RSP_DEPTH),
      .OUT_CREDITS (1)
   ) i_rsp_fifo (
      .clk  (clk),
      .nRst (nRst),
      .in   (rsp_in),
      .out  (rsp_out)
   );

   resp_sender i_resp_sender (
      .clk   (clk),
      .nRst  (nRst),
      .rsp   (rsp_out),
      .data  (tx_data),
      .start (tx_start),
      .busy  (tx_busy)
   );

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
      .clk   (clk),
      .nRst  (nRst),
      .data  (tx_data),
      .start (tx_start),
      .busy  (tx_busy),
      .tx    (tx)
   );

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic       clk,
   input  logic       nRst,
   input  logic       rx,
   output logic [7:0] data,
   output logic       byte_valid
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t        state;
   logic [1:0]       rx_sync;
   logic             rx_prev;
   logic [CNT_W-1:0] baud_cnt;
   logic [2:0]       bit_cnt;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         rx_sync    <= 2'b11;
         rx_prev    <= 1'b1;
         state      <= RX_IDLE;
         baud_cnt   <= '0;
         bit_cnt    <= '0;
         data       <= '0;
         byte_valid <= 1'b0;
      end else begin
         rx_sync    <= {rx_sync[0], rx};
         rx_prev    <= rx_sync[1];
         byte_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               baud_cnt <= '0;
               if (rx_prev && !rx_sync[1]) state <= RX_START;
            end
            RX_START: begin
               if (baud_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                  baud_cnt <= '0;
                  bit_cnt  <= '0;
                  state    <= rx_sync[1] ? RX_IDLE : RX_DATA;   // A short glitch is no start bit.
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (baud_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                  baud_cnt <= '0;
                  data     <= {rx_sync[1], data[7:1]};   // LSB arrives first.
                  bit_cnt  <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) state <= RX_STOP;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default: begin
               if (baud_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                  byte_valid <= rx_sync[1];   // Only a high stop bit completes the frame.
                  state      <= RX_IDLE;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
         endcase
      end
   end

   a_byte_valid_pulse: assert property (@(posedge clk) disable iff (!nRst)
      byte_valid |=> !byte_valid);

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic       clk,
   input  logic       nRst,
   input  logic [7:0] data,
   input  logic       start,
   output logic       busy,
   output logic       tx
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);

   logic [9:0]       shift;
   logic [3:0]       bit_cnt;
   logic [CNT_W-1:0] baud_cnt;

   assign tx = shift[0];   // All ones when idle, so the line rests high.

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         shift    <= '1;
         bit_cnt  <= '0;
         baud_cnt <= '0;
         busy     <= 1'b0;
      end else if (!busy) begin
         if (start) begin
            shift    <= {1'b1, data, 1'b0};
            bit_cnt  <= '0;
            baud_cnt <= '0;
            busy     <= 1'b1;
         end
      end else if (baud_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
         baud_cnt <= '0;
         shift    <= {1'b1, shift[9:1]};
         if (bit_cnt == 4'd9) begin
            busy <= 1'b0;   // Stop bit has been held for its full period.
         end else begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

   a_no_start_when_busy: assert property (@(posedge clk) disable iff (!nRst)
      start |-> !busy);

endmodule

`default_nettype wire

// File: sim.f
+incdir+testbench
rtl/u2g_pkg.sv
rtl/credit_link_if.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/cmd_parser.sv
rtl/credit_fifo.sv
rtl/gpio_exec.sv
rtl/resp_sender.sv
rtl/uart_gpio_top.sv
testbench/tb_uart_gpio.sv

// File: testbench/tb_uart_bfm.svh
`ifndef TB_UART_BFM_SVH
`define TB_UART_BFM_SVH

// Drives one 8N1 frame onto rx, starting and ending on a falling clock edge.
task automatic send_byte(input logic [7:0] b);
   int i;
   rx = 1'b0;   // Start bit.
   repeat (BIT_CLKS) @(negedge clk);
   for (i = 0; i < 8; i++) begin
      rx = b[i];
      repeat (BIT_CLKS) @(negedge clk);
   end
   rx = 1'b1;
   repeat (BIT_CLKS) @(negedge clk);
endtask

// Waits for a start bit on tx and samples every bit in its middle.
task automatic capture_byte(output logic [7:0] b, output logic stop_ok);
   int i;
   b = '0;
   @(negedge clk);
   while (tx !== 1'b0) @(negedge clk);
   repeat (BIT_CLKS / 2) @(negedge clk);
   for (i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk);
      b[i] = tx;
   end
   repeat (BIT_CLKS) @(negedge clk);
   stop_ok = (tx === 1'b1);
endtask

`endif

// File: testbench/tb_uart_gpio.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart_gpio;

   localparam int BIT_CLKS  = 16;
   localparam int NUM_BANKS = 4;
   localparam int GPIO_W    = NUM_BANKS * 8;
   localparam int FRAME_BYTES = 16 + 16 + 12 + 16 + 8 * 4;   // Read frames in the last test may be shorter.
   localparam int REPLY_BYTES = 4 + 4 + 8 + 4 + 8 * 2;
   localparam longint WATCHDOG_NS = longint'(FRAME_BYTES + REPLY_BYTES) * 10 * BIT_CLKS * 10 * 2;

   localparam logic [7:0] OP_READ    = "0";
   localparam logic [7:0] OP_WRITE   = "1";
   localparam logic [7:0] OP_CONFIG  = "2";
   localparam logic [7:0] REPLY_READ = "3";
   localparam logic [7:0] REPLY_WRITE  = "4";
   localparam logic [7:0] REPLY_CONFIG = "5";
   localparam logic [7:0] REPLY_ERROR  = "?";

   logic              clk;
   logic              nRst;
   logic              rx;
   logic              tx;
   logic [GPIO_W-1:0] gpio_in;
   logic [GPIO_W-1:0] gpio_out;
   logic [GPIO_W-1:0] gpio_oe;

   logic [GPIO_W-1:0] model_out;
   logic [GPIO_W-1:0] model_oe;
   logic [7:0]        exp_bytes[$];
   logic [31:0]       rnd_state;
   string             cur_test;
   int                errors;
   int                errors_at_start;
   int                tests_run;
   int                tests_failed;

   `include "tb_uart_bfm.svh"

   uart_gpio_top #(
      .CLKS_PER_BIT (BIT_CLKS),
      .NUM_BANKS    (NUM_BANKS),
      .CMD_DEPTH    (4),
      .RSP_DEPTH    (4)
   ) i_uart_gpio_top (
      .clk      (clk),
      .nRst     (nRst),
      .rx       (rx),
      .tx       (tx),
      .gpio_in  (gpio_in),
      .gpio_out (gpio_out),
      .gpio_oe  (gpio_oe)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rnd_state = xorshift32(rnd_state);
      return rnd_state;
   endfunction

   // Queues the expected reply and updates the pin model, then sends the frame.
   task automatic send_frame(input logic [7:0] op, input logic [7:0] bank,
                             input logic [7:0] pin, input logic [7:0] arg);
      logic ok;
      int   idx;
      ok  = (bank < NUM_BANKS) && (pin < 8);
      idx = ok ? bank * 8 + pin : 0;
      if (op == OP_READ) begin
         gpio_in = GPIO_W'(next_random());
         if (ok) begin
            exp_bytes.push_back(REPLY_READ);
            exp_bytes.push_back(8'h30 + 8'(gpio_in[idx]));
         end else begin
            exp_bytes.push_back(REPLY_ERROR);
         end
      end else if (!ok) begin
         exp_bytes.push_back(REPLY_ERROR);
      end else if (op == OP_WRITE) begin
         exp_bytes.push_back(REPLY_WRITE);
         model_out[idx] = arg[0];
      end else begin
         exp_bytes.push_back(REPLY_CONFIG);
         model_oe[idx] = arg[0];
      end
      send_byte(op);
      send_byte(bank);
      send_byte(pin);
      if (op != OP_READ) send_byte(arg);
   endtask

   task automatic start_test(input string name);
      cur_test        = name;
      errors_at_start = errors;
   endtask

   task automatic end_test();
      while (exp_bytes.size() != 0) @(negedge clk);
      repeat (BIT_CLKS) @(negedge clk);   // Let the last stop bit finish.
      assert (gpio_out == model_out) else begin
         $display("CHECK FAILED %s gpio_out: expected 0x%08h actual 0x%08h",
                  cur_test, model_out, gpio_out);
         errors++;
      end
      assert (gpio_oe == model_oe) else begin
         $display("CHECK FAILED %s gpio_oe: expected 0x%08h actual 0x%08h",
                  cur_test, model_oe, gpio_oe);
         errors++;
      end
      tests_run++;
      if (errors == errors_at_start) begin
         $display("test %s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", cur_test, errors - errors_at_start);
      end
   endtask

   task automatic reset_values();
      start_test("reset");
      assert (tx === 1'b1) else begin
         $display("CHECK FAILED %s tx: expected 1 actual %b", cur_test, tx);
         errors++;
      end
      end_test();
   endtask

   task automatic configure_pins();
      start_test("configure");
      send_frame(OP_CONFIG, 8'd0, 8'd3, 8'h01);
      send_frame(OP_CONFIG, 8'd2, 8'd7, 8'h33);
      send_frame(OP_CONFIG, 8'd3, 8'd0, 8'hff);
      send_frame(OP_CONFIG, 8'd2, 8'd7, 8'h02);   // Bit 0 low clears the pin again.
      end_test();
   endtask

   task automatic write_pins();
      start_test("write");
      send_frame(OP_WRITE, 8'd1, 8'd5, 8'h01);
      send_frame(OP_WRITE, 8'd3, 8'd7, "1");
      send_frame(OP_WRITE, 8'd0, 8'd0, 8'h81);
      send_frame(OP_WRITE, 8'd1, 8'd5, "0");
      end_test();
   endtask

   task automatic read_pins();
      start_test("read");
      send_frame(OP_READ, 8'd0, 8'd1, 8'h00);
      send_frame(OP_READ, 8'd1, 8'd6, 8'h00);
      send_frame(OP_READ, 8'd2, 8'd3, 8'h00);
      send_frame(OP_READ, 8'd3, 8'd7, 8'h00);
      end_test();
   endtask

   task automatic bad_frames();
      start_test("errors");
      send_byte("A");   // Not an opcode, so the parser stays idle.
      send_frame(OP_CONFIG, 8'd1, 8'd2, 8'h01);
      send_frame(OP_CONFIG, 8'd4, 8'd0, 8'h01);
      send_frame(OP_WRITE, 8'd1, 8'd8, 8'h01);
      send_frame(OP_READ, 8'd9, 8'd2, 8'h00);
      end_test();
   endtask

   task automatic back_to_back();
      logic [31:0] r;
      logic [7:0]  op;
      int          n;
      start_test("back_to_back");
      for (n = 0; n < 8; n++) begin
         r  = next_random();
         op = 8'h30 + 8'(r[7:0] % 3);
         send_frame(op, 8'(r[15:8] % 5), 8'(r[23:16] % 9), r[31:24]);
      end
      end_test();
   endtask

   initial begin : capture_loop
      logic [7:0] got;
      logic [7:0] want;
      logic       stop_ok;
      wait (nRst === 1'b1);
      forever begin
         capture_byte(got, stop_ok);
         assert (stop_ok) else begin
            $display("%s: reply byte 0x%02h ended with a low stop bit", cur_test, got);
            errors++;
         end
         assert (exp_bytes.size() != 0) else begin
            $display("%s: reply byte 0x%02h arrived when no reply was due", cur_test, got);
            errors++;
         end
         if (exp_bytes.size() != 0) begin
            want = exp_bytes.pop_front();
            assert (got == want) else begin
               $display("CHECK FAILED %s reply byte: expected 0x%02h actual 0x%02h",
                        cur_test, want, got);
               errors++;
            end
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired in test %s with %0d reply bytes still missing.",
               cur_test, exp_bytes.size());
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      clk          = 1'b0;
      nRst         = 1'b0;
      rx           = 1'b1;
      gpio_in      = '0;
      model_out    = '0;
      model_oe     = '0;
      rnd_state    = 32'd31;
      cur_test     = "reset";
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (4) @(negedge clk);
      nRst = 1'b1;
      @(negedge clk);
      reset_values();
      configure_pins();
      write_pins();
      read_pins();
      bad_frames();
      back_to_back();
      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
